//--- hdl/ata_pkg.sv
// Host-side definitions of the ATA task file: word and register types,
// register addresses, supported command codes and status bit positions
package ata_pkg;

	////////////////////////////////////////
	// Types

	typedef logic [15:0] ata_word_t;       // Host data bus word
	typedef logic [2:0]  ata_reg_addr_t;   // Task file register select
	typedef logic [7:0]  ata_status_t;     // Status register byte

	////////////////////////////////////////
	// Register map

	localparam ata_reg_addr_t REG_DATA       = 3'd0;
	localparam ata_reg_addr_t REG_SECT_CNT   = 3'd2;
	localparam ata_reg_addr_t REG_SECT_NUM   = 3'd3;
	localparam ata_reg_addr_t REG_CYL_LO     = 3'd4;
	localparam ata_reg_addr_t REG_CYL_HI     = 3'd5;
	localparam ata_reg_addr_t REG_CMD_STATUS = 3'd7;   // Command on write, status on read

	////////////////////////////////////////
	// Commands

	localparam logic [7:0] CMD_READ_SECTORS  = 8'h20;
	localparam logic [7:0] CMD_WRITE_SECTORS = 8'h30;

	////////////////////////////////////////
	// Status bits

	localparam int ST_BUSY = 7;
	localparam int ST_DRDY = 6;
	localparam int ST_DRQ  = 3;
	localparam int ST_ERR  = 0;

endpackage

//--- hdl/nand_pkg.sv
// Flash-side definitions: bus byte and address types, NAND opcodes,
// page geometry of the sector buffer and the sequencer states
package nand_pkg;

	////////////////////////////////////////
	// Types

	typedef logic [7:0]  nand_byte_t;   // Flash I/O bus byte
	typedef logic [31:0] nand_addr_t;   // Four address cycles, first cycle in [7:0]

	typedef enum logic {
		NOP_READ,
		NOP_PROGRAM
	} nand_op_t;

	////////////////////////////////////////
	// Opcodes and page size

	localparam nand_byte_t NAND_CMD_READ    = 8'h00;
	localparam nand_byte_t NAND_CMD_PROGRAM = 8'h80;
	localparam nand_byte_t NAND_CMD_CONFIRM = 8'h10;

	localparam int PAGE_WORDS = 8;
	localparam int PAGE_BYTES = 2 * PAGE_WORDS;
	localparam int BUF_PTR_W  = $clog2(PAGE_WORDS);

	////////////////////////////////////////
	// Sequencer states, named after the cycle on the pins

	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_CMD,         // we_n low, opcode on bus
		SEQ_CMD_HI,
		SEQ_ADDR,        // we_n low, address byte on bus
		SEQ_ADDR_HI,
		SEQ_WR,          // we_n low, data byte on bus
		SEQ_WR_HI,
		SEQ_CONF,        // we_n low, program confirm on bus
		SEQ_CONF_HI,
		SEQ_WAIT_LO,
		SEQ_WAIT_HI,
		SEQ_RD,          // re_n low, flash drives bus
		SEQ_RD_HI
	} seq_state_t;

endpackage

//--- hdl/bridge_ifs.sv
// Internal channels of the bridge: command handoff from the task file to the
// sequencer, and the push/pop ports of the shared sector buffer
`timescale 1ns/100ps

interface nand_cmd_if import nand_pkg::*; ();
	logic       start;   // One-cycle pulse, sequencer idle
	nand_op_t   op;
	nand_addr_t addr;
	logic       done;    // One pulse per start

	modport tf  (output start, output op, output addr, input done);
	modport seq (input start, input op, input addr, output done);
endinterface

interface buf_if import ata_pkg::*; ();
	logic      host_push;
	ata_word_t host_push_data;
	logic      host_pop;
	logic      nand_push;
	ata_word_t nand_push_data;
	logic      nand_pop;
	ata_word_t pop_data;     // Head word, valid while not empty
	logic      full;
	logic      empty;

	modport host_side (output host_push, output host_push_data, output host_pop,
		input pop_data);
	modport nand_side (output nand_push, output nand_push_data, output nand_pop,
		input pop_data, input full, input empty);
	modport store (input host_push, input host_push_data, input host_pop,
		input nand_push, input nand_push_data, input nand_pop,
		output pop_data, output full, output empty);
endinterface

//--- hdl/ata_task_file.sv
// Host register file: address registers, command decode, status, drq and intrq
// Data register accesses are routed to the sector buffer while drq is set
`timescale 1ns/100ps

module ata_task_file
	import ata_pkg::*;
	import nand_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          host_cs_i,
	input  logic          host_wr_i,
	input  logic          host_rd_i,
	input  ata_reg_addr_t host_addr_i,
	input  ata_word_t     host_data_i,
	output ata_word_t     host_data_o,
	output logic          host_data_oe_o,
	output logic          host_intrq_o,
	nand_cmd_if.tf        cmd,
	buf_if.host_side      sbuf
);

	logic                 wr_stb;
	logic                 rd_stb;
	logic                 busy;
	logic                 drq;
	logic                 err;
	logic                 intrq;
	logic                 start_q;
	nand_op_t             op_q;
	nand_addr_t           addr_q;
	logic [BUF_PTR_W-1:0] word_cnt;
	logic                 last_word;
	logic                 data_push;
	logic                 data_pop;
	ata_status_t          status;

	assign wr_stb    = host_cs_i & host_wr_i;
	assign rd_stb    = host_cs_i & host_rd_i;
	assign data_push = wr_stb && host_addr_i == REG_DATA && drq && op_q == NOP_PROGRAM;
	assign data_pop  = rd_stb && host_addr_i == REG_DATA && drq && op_q == NOP_READ;
	assign last_word = int'(word_cnt) == PAGE_WORDS - 1;

	always_comb begin
		status          = '0;
		status[ST_BUSY] = busy;
		status[ST_DRDY] = ~busy;
		status[ST_DRQ]  = drq;
		status[ST_ERR]  = err;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy           <= 1'b0;
			drq            <= 1'b0;
			err            <= 1'b0;
			intrq          <= 1'b0;
			start_q        <= 1'b0;
			op_q           <= NOP_READ;
			addr_q         <= '0;
			word_cnt       <= '0;
			host_data_oe_o <= 1'b0;
		end else begin
			start_q        <= 1'b0;
			host_data_oe_o <= rd_stb;
			if (rd_stb && host_addr_i == REG_CMD_STATUS)
				intrq <= 1'b0;   // Status read acknowledges
			if (wr_stb && !busy && !drq) begin
				case (host_addr_i)
					REG_SECT_CNT: addr_q[7:0]   <= host_data_i[7:0];
					REG_SECT_NUM: addr_q[15:8]  <= host_data_i[7:0];
					REG_CYL_LO:   addr_q[23:16] <= host_data_i[7:0];
					REG_CYL_HI:   addr_q[31:24] <= host_data_i[7:0];
					REG_CMD_STATUS: begin
						err      <= 1'b0;
						word_cnt <= '0;
						if (host_data_i[7:0] == CMD_READ_SECTORS) begin
							op_q    <= NOP_READ;
							busy    <= 1'b1;
							start_q <= 1'b1;
						end else if (host_data_i[7:0] == CMD_WRITE_SECTORS) begin
							op_q <= NOP_PROGRAM;
							drq  <= 1'b1;   // Host fills the buffer first
						end else begin
							err   <= 1'b1;
							intrq <= 1'b1;
						end
					end
					default: ;
				endcase
			end
			if (data_push || data_pop) begin
				word_cnt <= word_cnt + 1'b1;
				if (last_word) begin
					drq <= 1'b0;
					if (data_push) begin
						busy    <= 1'b1;   // Page complete, hand to flash
						start_q <= 1'b1;
					end
				end
			end
			if (cmd.done) begin
				busy     <= 1'b0;
				intrq    <= 1'b1;
				word_cnt <= '0;
				drq      <= op_q == NOP_READ;
			end
		end
	end

	// Read data register, valid the cycle after the strobe
	always_ff @(posedge clk) begin
		if (rd_stb) begin
			case (host_addr_i)
				REG_DATA:       host_data_o <= data_pop ? sbuf.pop_data : '0;
				REG_SECT_CNT:   host_data_o <= ata_word_t'(addr_q[7:0]);
				REG_SECT_NUM:   host_data_o <= ata_word_t'(addr_q[15:8]);
				REG_CYL_LO:     host_data_o <= ata_word_t'(addr_q[23:16]);
				REG_CYL_HI:     host_data_o <= ata_word_t'(addr_q[31:24]);
				REG_CMD_STATUS: host_data_o <= ata_word_t'(status);
				default:        host_data_o <= '0;
			endcase
		end
	end

	assign host_intrq_o        = intrq;
	assign cmd.start           = start_q;
	assign cmd.op              = op_q;
	assign cmd.addr            = addr_q;
	assign sbuf.host_push      = data_push;
	assign sbuf.host_push_data = host_data_i;
	assign sbuf.host_pop       = data_pop;

endmodule

//--- hdl/sector_buffer.sv
// One-page word FIFO between host and flash; one side fills it, the other drains it
`timescale 1ns/100ps

module sector_buffer
	import ata_pkg::*;
	import nand_pkg::*;
(
	input logic   clk,
	input logic   rst_n,
	buf_if.store  sbuf
);

	ata_word_t            mem [PAGE_WORDS];
	logic [BUF_PTR_W-1:0] wr_ptr;
	logic [BUF_PTR_W-1:0] rd_ptr;
	logic [BUF_PTR_W:0]   count;
	logic                 push;
	logic                 pop;
	ata_word_t            push_data;

	// Only one side is active at a time
	assign push      = (sbuf.host_push | sbuf.nand_push) & ~sbuf.full;
	assign pop       = (sbuf.host_pop | sbuf.nand_pop) & ~sbuf.empty;
	assign push_data = sbuf.host_push ? sbuf.host_push_data : sbuf.nand_push_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (int'(wr_ptr) == PAGE_WORDS - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (int'(rd_ptr) == PAGE_WORDS - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign sbuf.pop_data = mem[rd_ptr];   // Head word, pop advances it
	assign sbuf.full     = int'(count) == PAGE_WORDS;
	assign sbuf.empty    = count == '0;

endmodule

//--- hdl/nand_sequencer.sv
// NAND bus sequencer: command, four address cycles, page data and ready/busy wait
// All flash pins come straight from flops; one done pulse per start
`timescale 1ns/100ps

module nand_sequencer
	import nand_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	nand_cmd_if.seq    cmd,
	buf_if.nand_side   sbuf,
	input  nand_byte_t nand_io_i,
	input  logic       nand_rb_i,
	output nand_byte_t nand_io_o,
	output logic       nand_io_oe_o,
	output logic       nand_ale_o,
	output logic       nand_cle_o,
	output logic       nand_ce_n_o,
	output logic       nand_re_n_o,
	output logic       nand_we_n_o
);

	seq_state_t         state;
	logic [BUF_PTR_W:0] byte_cnt;   // Address index, then page byte index
	logic               done_q;
	nand_byte_t         io_q;
	nand_byte_t         lo_q;
	logic               io_oe_q;
	logic               ale_q;
	logic               cle_q;
	logic               ce_n_q;
	logic               re_n_q;
	logic               we_n_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= SEQ_IDLE;
			byte_cnt <= '0;
			done_q   <= 1'b0;
			io_q     <= '0;
			io_oe_q  <= 1'b0;
			ale_q    <= 1'b0;
			cle_q    <= 1'b0;
			ce_n_q   <= 1'b1;
			re_n_q   <= 1'b1;
			we_n_q   <= 1'b1;
		end else begin
			done_q <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (cmd.start) begin
						ce_n_q  <= 1'b0;
						cle_q   <= 1'b1;
						we_n_q  <= 1'b0;
						io_oe_q <= 1'b1;
						io_q    <= (cmd.op == NOP_READ) ? NAND_CMD_READ : NAND_CMD_PROGRAM;
						state   <= SEQ_CMD;
					end
				end
				SEQ_CMD: begin
					we_n_q <= 1'b1;   // Opcode latched on rising we_n
					state  <= SEQ_CMD_HI;
				end
				SEQ_CMD_HI: begin
					cle_q    <= 1'b0;
					ale_q    <= 1'b1;
					we_n_q   <= 1'b0;
					io_q     <= cmd.addr[7:0];
					byte_cnt <= '0;
					state    <= SEQ_ADDR;
				end
				SEQ_ADDR: begin
					we_n_q <= 1'b1;
					state  <= SEQ_ADDR_HI;
				end
				SEQ_ADDR_HI: begin
					if (byte_cnt[1:0] != 2'd3) begin
						byte_cnt <= byte_cnt + 1'b1;
						we_n_q   <= 1'b0;
						io_q     <= cmd.addr[8 * (byte_cnt[1:0] + 1) +: 8];
						state    <= SEQ_ADDR;
					end else if (cmd.op == NOP_READ) begin
						ale_q   <= 1'b0;
						io_oe_q <= 1'b0;   // Release bus for the flash
						state   <= SEQ_WAIT_LO;
					end else begin
						ale_q    <= 1'b0;
						we_n_q   <= 1'b0;
						byte_cnt <= '0;
						io_q     <= sbuf.pop_data[7:0];
						state    <= SEQ_WR;
					end
				end

				////////////////////////////////////////
				// Program data and confirm
				SEQ_WR: begin
					we_n_q <= 1'b1;
					state  <= SEQ_WR_HI;
				end
				SEQ_WR_HI: begin
					if (byte_cnt[0] && sbuf.empty) begin
						cle_q  <= 1'b1;
						we_n_q <= 1'b0;
						io_q   <= NAND_CMD_CONFIRM;
						state  <= SEQ_CONF;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
						we_n_q   <= 1'b0;
						io_q     <= byte_cnt[0] ? sbuf.pop_data[7:0] : sbuf.pop_data[15:8];
						state    <= SEQ_WR;
					end
				end
				SEQ_CONF: begin
					we_n_q <= 1'b1;
					state  <= SEQ_CONF_HI;
				end
				SEQ_CONF_HI: begin
					cle_q   <= 1'b0;
					io_oe_q <= 1'b0;
					state   <= SEQ_WAIT_LO;
				end

				////////////////////////////////////////
				// Ready/busy and page read
				SEQ_WAIT_LO: begin
					if (!nand_rb_i)
						state <= SEQ_WAIT_HI;
				end
				SEQ_WAIT_HI: begin
					if (nand_rb_i) begin
						byte_cnt <= '0;
						if (cmd.op == NOP_READ) begin
							re_n_q <= 1'b0;
							state  <= SEQ_RD;
						end else begin
							ce_n_q <= 1'b1;
							done_q <= 1'b1;
							state  <= SEQ_IDLE;
						end
					end
				end
				SEQ_RD: begin
					re_n_q <= 1'b1;   // Byte sampled on this edge
					state  <= SEQ_RD_HI;
				end
				SEQ_RD_HI: begin
					if (int'(byte_cnt) != PAGE_BYTES - 1) begin
						byte_cnt <= byte_cnt + 1'b1;
						re_n_q   <= 1'b0;
						state    <= SEQ_RD;
					end else if (sbuf.full) begin
						ce_n_q <= 1'b1;
						done_q <= 1'b1;
						state  <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Even bytes wait here for their high partner
	always_ff @(posedge clk) begin
		if (state == SEQ_RD && !byte_cnt[0])
			lo_q <= nand_io_i;
	end

	assign sbuf.nand_push      = state == SEQ_RD && byte_cnt[0];
	assign sbuf.nand_push_data = {nand_io_i, lo_q};
	assign sbuf.nand_pop       = state == SEQ_WR && byte_cnt[0];   // High byte already on bus
	assign cmd.done            = done_q;

	assign nand_io_o    = io_q;
	assign nand_io_oe_o = io_oe_q;
	assign nand_ale_o   = ale_q;
	assign nand_cle_o   = cle_q;
	assign nand_ce_n_o  = ce_n_q;
	assign nand_re_n_o  = re_n_q;
	assign nand_we_n_o  = we_n_q;

endmodule

//--- hdl/ide_nand_bridge.sv
// Top level of the ATA-to-NAND bridge: host task file, sector buffer and
// NAND sequencer joined by the command and buffer channels
`timescale 1ns/100ps

module ide_nand_bridge
	import ata_pkg::*;
	import nand_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	// Host port
	input  logic          host_cs_i,
	input  logic          host_wr_i,
	input  logic          host_rd_i,
	input  ata_reg_addr_t host_addr_i,
	input  ata_word_t     host_data_i,
	output ata_word_t     host_data_o,
	output logic          host_data_oe_o,
	output logic          host_intrq_o,
	// Flash port
	input  nand_byte_t    nand_io_i,
	input  logic          nand_rb_i,
	output nand_byte_t    nand_io_o,
	output logic          nand_io_oe_o,
	output logic          nand_ale_o,
	output logic          nand_cle_o,
	output logic          nand_ce_n_o,
	output logic          nand_re_n_o,
	output logic          nand_we_n_o
);

	nand_cmd_if cmd_ch ();
	buf_if      buf_ch ();

	ata_task_file u_task_file (
		.clk            (clk),
		.rst_n          (rst_n),
		.host_cs_i      (host_cs_i),
		.host_wr_i      (host_wr_i),
		.host_rd_i      (host_rd_i),
		.host_addr_i    (host_addr_i),
		.host_data_i    (host_data_i),
		.host_data_o    (host_data_o),
		.host_data_oe_o (host_data_oe_o),
		.host_intrq_o   (host_intrq_o),
		.cmd            (cmd_ch.tf),
		.sbuf           (buf_ch.host_side)
	);

	sector_buffer u_buffer (
		.clk   (clk),
		.rst_n (rst_n),
		.sbuf  (buf_ch.store)
	);

	nand_sequencer u_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd          (cmd_ch.seq),
		.sbuf         (buf_ch.nand_side),
		.nand_io_i    (nand_io_i),
		.nand_rb_i    (nand_rb_i),
		.nand_io_o    (nand_io_o),
		.nand_io_oe_o (nand_io_oe_o),
		.nand_ale_o   (nand_ale_o),
		.nand_cle_o   (nand_cle_o),
		.nand_ce_n_o  (nand_ce_n_o),
		.nand_re_n_o  (nand_re_n_o),
		.nand_we_n_o  (nand_we_n_o)
	);

endmodule

//--- bench/nand_flash_model.sv
// Behavioral NAND flash for the bridge bench: page memory, a log of latched cycles
// and a random ready/busy time after the read address and after program confirm
`timescale 1ns/100ps

module nand_flash_model
	import nand_pkg::*;
(
	input  logic       clk,
	input  nand_byte_t io_i,      // Bus driven by the bridge
	input  logic       io_oe_i,
	input  logic       ale_i,
	input  logic       cle_i,
	input  logic       ce_n_i,
	input  logic       re_n_i,
	input  logic       we_n_i,
	output nand_byte_t io_o,
	output logic       rb_o
);

	typedef logic [8*PAGE_BYTES-1:0] page_t;   // Byte j in [8j+7:8j]

	page_t      mem [nand_addr_t];
	logic [9:0] cyc_log [$];                   // {cle, ale, byte} per latched cycle
	nand_byte_t opcode   = 8'hff;
	nand_addr_t addr     = '0;
	page_t      wr_page  = '0;
	int         addr_idx = 0;
	int         data_idx = 0;
	nand_byte_t io_q     = '0;
	logic       rb_q     = 1'b1;

	// Unwritten pages read back a pattern of the whole address
	function automatic nand_byte_t page_byte(input nand_addr_t a, input int i);
		page_t p;
		if (!mem.exists(a))
			return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ nand_byte_t'(i);
		p = mem[a];
		return p[8*i +: 8];
	endfunction

	task automatic go_busy();
		int busy_cycles;
		busy_cycles = $urandom_range(20, 1);
		@(negedge clk);
		rb_q = 1'b0;
		repeat (busy_cycles + 2) @(negedge clk);   // Covers the sequencer's way into its wait
		rb_q = 1'b1;
	endtask

	always @(posedge we_n_i or negedge re_n_i) begin
		if (!ce_n_i && !re_n_i) begin
			io_q = page_byte(addr, data_idx);   // Next byte out on falling re_n
			data_idx++;
		end else if (!ce_n_i && io_oe_i) begin
			cyc_log.push_back({cle_i, ale_i, io_i});
			if (cle_i && io_i == NAND_CMD_CONFIRM) begin
				mem[addr] = wr_page;
				go_busy();
			end else if (cle_i) begin
				opcode   = io_i;
				addr_idx = 0;
				data_idx = 0;
			end else if (ale_i) begin
				addr[8*addr_idx +: 8] = io_i;
				addr_idx++;
				if (addr_idx == 4 && opcode == NAND_CMD_READ)
					go_busy();
			end else if (data_idx < PAGE_BYTES) begin
				wr_page[8*data_idx +: 8] = io_i;
				data_idx++;
			end
		end
	end

	////////////////////////////////////////
	// Access for the testbench

	task automatic clear_log();
		cyc_log.delete();
	endtask

	function automatic int log_size();
		return cyc_log.size();
	endfunction

	function automatic logic [9:0] log_entry(input int i);
		return cyc_log[i];
	endfunction

	task automatic preload_page(input nand_addr_t a, input page_t data);
		mem[a] = data;
	endtask

	assign io_o = io_q;
	assign rb_o = rb_q;

endmodule

//--- bench/tb_bridge.sv
// Testbench of the ATA-to-NAND bridge. Random pages go through the task file
// and are checked against a page model and the cycles the flash model logged
`timescale 1ns/100ps

module tb_bridge
	import ata_pkg::*;
	import nand_pkg::*;
();

	localparam int         WAIT_LIMIT = 1000;   // Cycles per command
	localparam logic [1:0] KIND_CMD   = 2'b10;   // {cle, ale}
	localparam logic [1:0] KIND_ADDR  = 2'b01;
	localparam logic [1:0] KIND_DATA  = 2'b00;

	typedef logic [8*PAGE_BYTES-1:0] page_t;   // Byte j in [8j+7:8j]

	logic          clk = 1'b0;
	logic          rst_n;
	logic          host_cs;
	logic          host_wr;
	logic          host_rd;
	ata_reg_addr_t host_addr;
	ata_word_t     host_wdata;
	ata_word_t     host_rdata;
	logic          host_data_oe;
	logic          host_intrq;
	nand_byte_t    nand_io_in;
	nand_byte_t    nand_io_out;
	logic          nand_rb;
	logic          nand_io_oe;
	logic          nand_ale;
	logic          nand_cle;
	logic          nand_ce_n;
	logic          nand_re_n;
	logic          nand_we_n;

	page_t ref_pages [nand_addr_t];
	int    word_errs   = 0;
	int    status_errs = 0;
	int    byte_errs   = 0;
	int    other_errs  = 0;

	always #20 clk = ~clk;

	ide_nand_bridge UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.host_cs_i      (host_cs),
		.host_wr_i      (host_wr),
		.host_rd_i      (host_rd),
		.host_addr_i    (host_addr),
		.host_data_i    (host_wdata),
		.host_data_o    (host_rdata),
		.host_data_oe_o (host_data_oe),
		.host_intrq_o   (host_intrq),
		.nand_io_i      (nand_io_in),
		.nand_rb_i      (nand_rb),
		.nand_io_o      (nand_io_out),
		.nand_io_oe_o   (nand_io_oe),
		.nand_ale_o     (nand_ale),
		.nand_cle_o     (nand_cle),
		.nand_ce_n_o    (nand_ce_n),
		.nand_re_n_o    (nand_re_n),
		.nand_we_n_o    (nand_we_n)
	);

	nand_flash_model flash (
		.clk     (clk),
		.io_i    (nand_io_out),
		.io_oe_i (nand_io_oe),
		.ale_i   (nand_ale),
		.cle_i   (nand_cle),
		.ce_n_i  (nand_ce_n),
		.re_n_i  (nand_re_n),
		.we_n_i  (nand_we_n),
		.io_o    (nand_io_in),
		.rb_o    (nand_rb)
	);

	////////////////////////////////////////
	// Compare tasks

	task automatic check_word(input ata_word_t got, input ata_word_t exp, input string what);
		if (got !== exp) begin
			word_errs++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(input ata_status_t got, input ata_status_t exp,
		input string what);
		if (got !== exp) begin
			status_errs++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_nand_byte(input nand_byte_t got, input nand_byte_t exp,
		input string what);
		if (got !== exp) begin
			byte_errs++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Host bus and expectations

	task automatic host_write(input ata_reg_addr_t a, input ata_word_t d);
		@(negedge clk);
		host_cs    = 1'b1;
		host_wr    = 1'b1;
		host_addr  = a;
		host_wdata = d;
		@(negedge clk);
		host_cs = 1'b0;
		host_wr = 1'b0;
	endtask

	task automatic host_read(input ata_reg_addr_t a, output ata_word_t d);
		@(negedge clk);
		host_cs   = 1'b1;
		host_rd   = 1'b1;
		host_addr = a;
		@(negedge clk);
		host_cs = 1'b0;
		host_rd = 1'b0;
		d       = host_rdata;   // Registered on the edge in between
		if (host_data_oe !== 1'b1) begin
			other_errs++;
			$display("[ERROR] %0t ns: host data not enabled after the read strobe", $time);
		end
	endtask

	function automatic ata_status_t status_bits(input logic drq, input logic err);
		ata_status_t s;
		s          = '0;
		s[ST_DRDY] = 1'b1;
		s[ST_DRQ]  = drq;
		s[ST_ERR]  = err;
		return s;
	endfunction

	function automatic page_t random_page();
		page_t p;
		for (int j = 0; j < PAGE_BYTES; j++)
			p[8*j +: 8] = nand_byte_t'($urandom);
		return p;
	endfunction

	task automatic wait_intrq(input string what);
		int cycles;
		cycles = 0;
		while (!host_intrq && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!host_intrq) begin
			other_errs++;
			$display("Timeout: no interrupt after %s", what);
		end
	endtask

	// Status read also acknowledges the interrupt
	task automatic expect_status(input ata_status_t exp, input string what);
		ata_word_t w;
		host_read(REG_CMD_STATUS, w);
		check_status(w[7:0], exp, what);
		if (host_intrq !== 1'b0) begin
			other_errs++;
			$display("[ERROR] %0t ns: interrupt still pending after the status read (%s)",
				$time, what);
		end
	endtask

	task automatic set_address(input nand_addr_t a);
		host_write(REG_SECT_CNT, {8'h00, a[7:0]});
		host_write(REG_SECT_NUM, {8'h00, a[15:8]});
		host_write(REG_CYL_LO, {8'h00, a[23:16]});
		host_write(REG_CYL_HI, {8'h00, a[31:24]});
	endtask

	task automatic check_log_length(input int n, input string what);
		if (flash.log_size() != n) begin
			other_errs++;
			$display("[ERROR] %0t ns: flash saw %0d cycles for %s, expected %0d",
				$time, flash.log_size(), what, n);
		end
	endtask

	task automatic expect_cycle(input int i, input logic [1:0] kind, input nand_byte_t b,
		input string what);
		logic [9:0] e;
		if (i >= flash.log_size()) begin
			other_errs++;
			$display("Flash cycle %0d (%s) never happened", i, what);
		end else begin
			e = flash.log_entry(i);
			if (e[9:8] !== kind) begin
				other_errs++;
				$display("[ERROR] %0t ns: flash cycle %0d (%s) had cle/ale %b, expected %b",
					$time, i, what, e[9:8], kind);
			end
			check_nand_byte(e[7:0], b, what);
		end
	endtask

	task automatic check_addr_cycles(input nand_addr_t a);
		expect_cycle(1, KIND_ADDR, a[7:0], "address byte 0");
		expect_cycle(2, KIND_ADDR, a[15:8], "address byte 1");
		expect_cycle(3, KIND_ADDR, a[23:16], "address byte 2");
		expect_cycle(4, KIND_ADDR, a[31:24], "address byte 3");
	endtask

	////////////////////////////////////////
	// Page transfers

	task automatic write_page(input nand_addr_t a, input page_t data);
		int i;
		flash.clear_log();
		set_address(a);
		host_write(REG_CMD_STATUS, ata_word_t'(CMD_WRITE_SECTORS));
		for (i = 0; i < PAGE_WORDS; i++)
			host_write(REG_DATA, {data[8*(2*i+1) +: 8], data[8*(2*i) +: 8]});
		wait_intrq("WRITE SECTORS");
		expect_status(status_bits(1'b0, 1'b0), "status after write");
		check_log_length(6 + PAGE_BYTES, "WRITE SECTORS");
		expect_cycle(0, KIND_CMD, NAND_CMD_PROGRAM, "program opcode");
		check_addr_cycles(a);
		for (i = 0; i < PAGE_BYTES; i++)
			expect_cycle(5 + i, KIND_DATA, data[8*i +: 8], "program data byte");
		expect_cycle(5 + PAGE_BYTES, KIND_CMD, NAND_CMD_CONFIRM, "program confirm");
		ref_pages[a] = data;
	endtask

	task automatic read_page(input nand_addr_t a);
		int        i;
		ata_word_t w;
		page_t     expected;
		expected = ref_pages[a];
		flash.clear_log();
		set_address(a);
		host_write(REG_CMD_STATUS, ata_word_t'(CMD_READ_SECTORS));
		wait_intrq("READ SECTORS");
		check_log_length(5, "READ SECTORS");
		expect_cycle(0, KIND_CMD, NAND_CMD_READ, "read opcode");
		check_addr_cycles(a);
		expect_status(status_bits(1'b1, 1'b0), "status after read");
		for (i = 0; i < PAGE_WORDS; i++) begin
			host_read(REG_DATA, w);
			check_word(w, {expected[8*(2*i+1) +: 8], expected[8*(2*i) +: 8]}, "page word");
		end
		expect_status(status_bits(1'b0, 1'b0), "status after last data read");
	endtask

	////////////////////////////////////////
	// Stimulus

	initial begin
		ata_word_t  w;
		nand_addr_t a;
		page_t      p;
		void'($urandom(79));
		host_cs    = 1'b0;
		host_wr    = 1'b0;
		host_rd    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		rst_n      = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		if (host_intrq !== 1'b0) begin
			other_errs++;
			$display("[ERROR] %0t ns: interrupt pending after reset", $time);
		end
		if (host_data_oe !== 1'b0) begin
			other_errs++;
			$display("[ERROR] %0t ns: host data enabled after reset", $time);
		end
		host_read(REG_CMD_STATUS, w);
		check_status(w[7:0], status_bits(1'b0, 1'b0), "status after reset");

		write_page($urandom, random_page());

		a = $urandom;
		p = random_page();
		flash.preload_page(a, p);
		ref_pages[a] = p;
		read_page(a);

		repeat (4) begin   // Round trips
			a = $urandom;
			write_page(a, random_page());
			read_page(a);
		end

		flash.clear_log();
		host_write(REG_CMD_STATUS, 16'h00ec);
		wait_intrq("unknown command");
		expect_status(status_bits(1'b0, 1'b1), "status after unknown command");
		check_log_length(0, "unknown command");

		// Data writes outside drq
		a = $urandom;
		write_page(a, random_page());
		host_write(REG_DATA, ata_word_t'($urandom));
		write_page(a, random_page());
		read_page(a);

		$display("Errors: %0d word, %0d status, %0d flash byte, %0d other",
			word_errs, status_errs, byte_errs, other_errs);
		if (word_errs + status_errs + byte_errs + other_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- flist.f
hdl/ata_pkg.sv
hdl/nand_pkg.sv
hdl/bridge_ifs.sv
hdl/ata_task_file.sv
hdl/sector_buffer.sv
hdl/nand_sequencer.sv
hdl/ide_nand_bridge.sv
bench/nand_flash_model.sv
bench/tb_bridge.sv

//--- Makefile
TOP := tb_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
